/* rename_settings.svh */
//--------------------------------------------------------------------------
// Sizing macros for the rename and issue stage
// Physical and architectural register counts, sequence-number width
//--------------------------------------------------------------------------

`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Physical registers in the register file
`define RN_NUM_PREGS 36

// Architectural registers seen by software
`define RN_NUM_AREGS 32

// Width of the in-flight sequence number
`define RN_SEQ_BITS 8

`endif

/* rename_pkg.sv */
//--------------------------------------------------------------------------
// Shared types for the decode, rename and issue stage
// Register indices, uop encoding, instruction word views, channel records
//--------------------------------------------------------------------------

`default_nettype none

`include "rename_settings.svh"

package rename_pkg;

  typedef logic [$clog2(`RN_NUM_PREGS)-1:0] preg_t;
  typedef logic [$clog2(`RN_NUM_AREGS)-1:0] areg_t;
  typedef logic [`RN_SEQ_BITS-1:0]          seq_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [3:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_ADDI,
    UOP_ANDI,
    UOP_LUI,
    UOP_ILLEGAL
  } uop_t;

  // Register-register view
  typedef struct packed {
    logic [6:0] funct7;
    areg_t      rs2;
    areg_t      rs1;
    logic [2:0] funct3;
    areg_t      rd;
    logic [6:0] opcode;
  } r_fields_t;

  // Register-immediate view
  typedef struct packed {
    logic [11:0] imm12;
    areg_t       rs1;
    logic [2:0]  funct3;
    areg_t       rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // One instruction word, decoded through either view
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_word_u;

  typedef struct packed {
    inst_word_u  inst;
    logic [31:0] pc;
    seq_t        seq;
  } fetch_item_t;

  typedef struct packed {
    uop_t        uop;
    logic [31:0] op1;
    logic [31:0] op2;
    areg_t       waddr;
    preg_t       preg;
    preg_t       ppreg;
    seq_t        seq;
    logic [31:0] pc;
  } issue_item_t;

  typedef struct packed {
    logic        val;
    logic        wen;
    preg_t       preg;
    preg_t       ppreg;
    areg_t       waddr;
    logic [31:0] wdata;
    seq_t        seq;
  } complete_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
//--------------------------------------------------------------------------
// Instruction decoder with immediate generation
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  rename_pkg::inst_word_u inst,
  output logic                   legal,
  output rename_pkg::uop_t       uop,
  output rename_pkg::areg_t      raddr0,
  output rename_pkg::areg_t      raddr1,
  output rename_pkg::areg_t      waddr,
  output logic                   wen,
  output logic                   op2_imm,
  output logic [31:0]            imm
);

  import rename_pkg::*;

  logic [31:0] i_imm;
  logic [31:0] u_imm;

  // Sign-extended 12-bit immediate from the I view
  assign i_imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
  // Upper 20 bits, taken across the R view fields
  assign u_imm = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};

  always_comb begin
    legal   = 1'b1;
    uop     = UOP_ILLEGAL;
    raddr0  = inst.r.rs1;
    raddr1  = inst.r.rs2;
    waddr   = inst.r.rd;
    op2_imm = 1'b0;
    imm     = i_imm;

    case (inst.r.opcode)
      OPC_OP: begin
        case ({inst.r.funct7, inst.r.funct3})
          {7'b0000000, 3'b000}: uop = UOP_ADD;
          {7'b0100000, 3'b000}: uop = UOP_SUB;
          {7'b0000000, 3'b111}: uop = UOP_AND;
          {7'b0000000, 3'b110}: uop = UOP_OR;
          {7'b0000000, 3'b100}: uop = UOP_XOR;
          default:              legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // rs2 field holds immediate bits, so never look it up
        raddr1  = '0;
        op2_imm = 1'b1;
        case (inst.i.funct3)
          3'b000:  uop = UOP_ADDI;
          3'b111:  uop = UOP_ANDI;
          default: legal = 1'b0;
        endcase
      end
      OPC_LUI: begin
        // op1 reads x0, op2 carries the upper immediate
        uop     = UOP_LUI;
        raddr0  = '0;
        raddr1  = '0;
        op2_imm = 1'b1;
        imm     = u_imm;
      end
      default: legal = 1'b0;
    endcase

    // No write for x0 or anything undecodable
    wen = legal && (waddr != '0);
  end

endmodule

`default_nettype wire

/* rename_table.sv */
//--------------------------------------------------------------------------
// Register rename table
// Architectural map, free vector and pending bits per physical register
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module rename_table (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alloc_en,
  input  rename_pkg::areg_t     alloc_areg,
  output rename_pkg::preg_t     alloc_preg,
  output rename_pkg::preg_t     alloc_ppreg,
  output logic                  alloc_rdy,
  input  rename_pkg::areg_t     lookup_areg [2],
  output rename_pkg::preg_t     lookup_preg [2],
  output logic                  lookup_pending [2],
  input  rename_pkg::complete_t complete
);

  import rename_pkg::*;

  preg_t                   map [`RN_NUM_AREGS];
  logic [`RN_NUM_PREGS-1:0] free_vec;
  logic [`RN_NUM_PREGS-1:0] pending;
  logic                    retire;

  // Only writing completions touch rename state
  assign retire = complete.val && complete.wen;

  //--------------------------------------------------------------------------
  // Allocation side
  //--------------------------------------------------------------------------

  assign alloc_rdy   = |free_vec;
  assign alloc_ppreg = map[alloc_areg];

  // Lowest-numbered free register wins
  always_comb begin
    alloc_preg = '0;
    for (int i = `RN_NUM_PREGS - 1; i >= 0; i--) begin
      if (free_vec[i])
        alloc_preg = preg_t'(i);
    end
  end

  // Source lookups
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      lookup_preg[k]    = map[lookup_areg[k]];
      lookup_pending[k] = pending[lookup_preg[k]];
    end
  end

  //--------------------------------------------------------------------------
  // State update
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, spare registers free
      for (int i = 0; i < `RN_NUM_AREGS; i++)
        map[i] <= preg_t'(i);
      free_vec <= {{(`RN_NUM_PREGS - `RN_NUM_AREGS){1'b1}}, {`RN_NUM_AREGS{1'b0}}};
      pending  <= '0;
    end else begin
      // Completion frees the old mapping and wakes readers
      if (retire) begin
        pending[complete.preg]   <= 1'b0;
        free_vec[complete.ppreg] <= 1'b1;
      end
      // Alloc never collides with a completion, it picks an already free reg
      if (alloc_en) begin
        map[alloc_areg]      <= alloc_preg;
        free_vec[alloc_preg] <= 1'b0;
        pending[alloc_preg]  <= 1'b1;
      end
    end
  end

  // Issue logic must hold off writers when nothing is free
  a_alloc_when_rdy: assert property (@(posedge clk) disable iff (rst)
    alloc_en |-> alloc_rdy);

  // Pipe only completes registers that were allocated
  a_complete_pending: assert property (@(posedge clk) disable iff (rst)
    retire |-> pending[complete.preg]);

endmodule

`default_nettype wire

/* phys_regfile.sv */
//--------------------------------------------------------------------------
// Physical register file, two read ports and one write port
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module phys_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rename_pkg::preg_t raddr [2],
  output logic [31:0]       rdata [2],
  input  rename_pkg::preg_t waddr,
  input  logic [31:0]       wdata,
  input  logic              wen
);

  import rename_pkg::*;

  logic [31:0] regs [`RN_NUM_PREGS];

  // Combinational reads, preg 0 always reads zero
  always_comb begin
    for (int k = 0; k < 2; k++)
      rdata[k] = (raddr[k] == '0) ? 32'b0 : regs[raddr[k]];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RN_NUM_PREGS; i++)
        regs[i] <= 32'b0;
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is never renamed, so no completion targets preg 0
  a_no_preg0_write: assert property (@(posedge clk) disable iff (rst)
    wen |-> (waddr != '0));

endmodule

`default_nettype wire

/* decode_issue_unit.sv */
//--------------------------------------------------------------------------
// Decode and issue unit
// Fetch input register, rename, operand read, stall and issue to the pipe
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module decode_issue_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_val,
  input  rename_pkg::fetch_item_t fetch,
  output logic                    fetch_rdy,
  output logic                    issue_val,
  output rename_pkg::issue_item_t issue,
  input  rename_pkg::complete_t   complete
);

  import rename_pkg::*;

  //--------------------------------------------------------------------------
  // Fetch input register
  //--------------------------------------------------------------------------

  logic        f_val;
  fetch_item_t f_item;
  logic        fetch_xfer;
  logic        issue_xfer;

  assign fetch_xfer = fetch_val && fetch_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      f_val <= 1'b0;
    else if (fetch_xfer)
      f_val <= 1'b1;
    else if (issue_xfer)
      f_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer)
      f_item <= fetch;
  end

  //--------------------------------------------------------------------------
  // Decode, rename and operand read
  //--------------------------------------------------------------------------

  logic        dec_legal;
  uop_t        dec_uop;
  areg_t       dec_raddr0;
  areg_t       dec_raddr1;
  areg_t       dec_waddr;
  logic        dec_wen;
  logic        dec_op2_imm;
  logic [31:0] dec_imm;

  inst_decoder decoder_i (
    .inst    (f_item.inst),
    .legal   (dec_legal),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .op2_imm (dec_op2_imm),
    .imm     (dec_imm)
  );

  areg_t       src_areg [2];
  preg_t       src_preg [2];
  logic        src_pending [2];
  preg_t       alloc_preg;
  preg_t       alloc_ppreg;
  logic        alloc_rdy;
  logic [31:0] rf_rdata [2];
  logic        stall;

  assign src_areg[0] = dec_raddr0;
  assign src_areg[1] = dec_raddr1;

  rename_table rename_table_i (
    .clk            (clk),
    .rst            (rst),
    .alloc_en       (issue_xfer && dec_wen),
    .alloc_areg     (dec_waddr),
    .alloc_preg     (alloc_preg),
    .alloc_ppreg    (alloc_ppreg),
    .alloc_rdy      (alloc_rdy),
    .lookup_areg    (src_areg),
    .lookup_preg    (src_preg),
    .lookup_pending (src_pending),
    .complete       (complete)
  );

  // Written at the completion edge, read by the stalled dependent next cycle
  phys_regfile regfile_i (
    .clk   (clk),
    .rst   (rst),
    .raddr (src_preg),
    .rdata (rf_rdata),
    .waddr (complete.preg),
    .wdata (complete.wdata),
    .wen   (complete.val && complete.wen)
  );

  //--------------------------------------------------------------------------
  // Stall and issue
  //--------------------------------------------------------------------------

  // Writers need a free reg and every source must be ready
  assign stall      = (dec_wen && !alloc_rdy) || src_pending[0] || src_pending[1];
  assign issue_xfer = f_val && dec_legal && !stall;
  assign issue_val  = issue_xfer;

  // Accept a new item when empty or draining this cycle
  assign fetch_rdy = !f_val || issue_xfer;

  always_comb begin
    issue.uop   = dec_uop;
    issue.op1   = rf_rdata[0];
    issue.op2   = dec_op2_imm ? dec_imm : rf_rdata[1];
    issue.waddr = dec_waddr;
    // Non-writers carry no rename info
    issue.preg  = dec_wen ? alloc_preg : '0;
    issue.ppreg = dec_wen ? alloc_ppreg : '0;
    issue.seq   = f_item.seq;
    issue.pc    = f_item.pc;
  end

  // Fetch source keeps a refused item steady until it is taken
  a_fetch_held: assert property (@(posedge clk) disable iff (rst)
    (fetch_val && !fetch_rdy) |=> (fetch_val && $stable(fetch)));

endmodule

`default_nettype wire

/* int_pipe.sv */
//--------------------------------------------------------------------------
// Two-stage integer pipe producing completion records
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_pipe (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_val,
  input  rename_pkg::issue_item_t issue,
  output rename_pkg::complete_t   complete
);

  import rename_pkg::*;

  logic        s1_val;
  issue_item_t s1_item;
  logic        s2_val;
  complete_t   s2_next;
  complete_t   s2_rec;
  logic [31:0] alu_out;

  // Stage 1 captures the issued item
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else begin
      s1_val <= issue_val;
      s2_val <= s1_val;
    end
  end

  always_comb begin
    case (s1_item.uop)
      UOP_ADD, UOP_ADDI: alu_out = s1_item.op1 + s1_item.op2;
      UOP_SUB:           alu_out = s1_item.op1 - s1_item.op2;
      UOP_AND, UOP_ANDI: alu_out = s1_item.op1 & s1_item.op2;
      UOP_OR:            alu_out = s1_item.op1 | s1_item.op2;
      UOP_XOR:           alu_out = s1_item.op1 ^ s1_item.op2;
      UOP_LUI:           alu_out = s1_item.op2;
      default:           alu_out = 32'b0;
    endcase

    s2_next.val   = s1_val;
    s2_next.wen   = (s1_item.waddr != '0);
    s2_next.preg  = s1_item.preg;
    s2_next.ppreg = s1_item.ppreg;
    s2_next.waddr = s1_item.waddr;
    s2_next.wdata = alu_out;
    s2_next.seq   = s1_item.seq;
  end

  // Payload registers
  always_ff @(posedge clk) begin
    s1_item <= issue;
    s2_rec  <= s2_next;
  end

  // Stage 2 drives the broadcast, valid from the reset-cleared flag
  always_comb begin
    complete     = s2_rec;
    complete.val = s2_val;
  end

endmodule

`default_nettype wire

/* decode_issue_top.sv */
//--------------------------------------------------------------------------
// Top level of the decode and issue stage with its integer pipe
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module decode_issue_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_val,
  input  rename_pkg::fetch_item_t fetch,
  output logic                    fetch_rdy,
  output rename_pkg::complete_t   complete
);

  import rename_pkg::*;

  logic        issue_val;
  issue_item_t issue;

  decode_issue_unit unit_i (
    .clk       (clk),
    .rst       (rst),
    .fetch_val (fetch_val),
    .fetch     (fetch),
    .fetch_rdy (fetch_rdy),
    .issue_val (issue_val),
    .issue     (issue),
    .complete  (complete)
  );

  // Always ready, so no handshake back to the unit
  int_pipe pipe_i (
    .clk       (clk),
    .rst       (rst),
    .issue_val (issue_val),
    .issue     (issue),
    .complete  (complete)
  );

endmodule

`default_nettype wire

/* tb_decode_issue.sv */
//--------------------------------------------------------------------------
// Directed testbench for the decode and issue stage
// Architectural reference model, in-order completion and rename checks, watchdog
//--------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "rename_settings.svh"

module tb_decode_issue;

  import rename_pkg::*;

  // Instruction counts per test, used to size the watchdog
  localparam int ALU_INSTS       = 9;
  localparam int CHAIN_INSTS     = 9;
  localparam int FREE_INSTS      = 9;
  localparam int RANDOM_INSTS    = 40;
  localparam int X0_INSTS        = 5;
  localparam int TOTAL_INSTS     = ALU_INSTS + CHAIN_INSTS + FREE_INSTS + RANDOM_INSTS + X0_INSTS;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 20;
  localparam int DRAIN_LIMIT     = 60;

  // Predicted completion, kept in fetch order
  typedef struct packed {
    areg_t       waddr;
    logic        wen;
    logic [31:0] wdata;
    seq_t        seq;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        fetch_val;
  fetch_item_t fetch_in;
  logic        fetch_rdy;
  complete_t   complete;

  logic [31:0] arf [`RN_NUM_AREGS];
  expect_t     exp_q [$];
  seq_t        next_seq;
  int          seed;
  // Rename map as of the last completed write of each areg
  preg_t       pmap [`RN_NUM_AREGS];

  decode_issue_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .fetch_val (fetch_val),
    .fetch     (fetch_in),
    .fetch_rdy (fetch_rdy),
    .complete  (complete)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Failure reporting and checking
  //--------------------------------------------------------------------------

  task automatic end_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
      end_with_failure();
    end
  endtask

  // Old mapping comes back as ppreg, new preg was not mapped anywhere
  task automatic check_rename(input areg_t waddr, input preg_t preg, input preg_t ppreg);
    int clash;
    clash = -1;
    for (int i = 0; i < `RN_NUM_AREGS; i++) begin
      if (preg == pmap[i])
        clash = i;
    end
    check_value("complete.ppreg", 32'(ppreg), 32'(pmap[waddr]));
    if (clash >= 0) begin
      $display("Completion got preg %0d which x%0d still maps to", preg, clash);
      end_with_failure();
    end else begin
      pmap[waddr] = preg;
    end
  endtask

  // Ends the run if tests outlive their instruction budget
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  // Completion record is registered, so the falling edge sees it settled
  always @(negedge clk) begin : completion_monitor
    expect_t e;
    if (!rst && complete.val) begin
      if (exp_q.size() == 0) begin
        $display("Completion for seq 0x%02h arrived with nothing outstanding", complete.seq);
        end_with_failure();
      end else begin
        e = exp_q.pop_front();
        check_value("complete.seq", 32'(complete.seq), 32'(e.seq));
        check_value("complete.waddr", 32'(complete.waddr), 32'(e.waddr));
        check_value("complete.wen", 32'(complete.wen), 32'(e.wen));
        check_value("complete.wdata", complete.wdata, e.wdata);
        if (complete.wen)
          check_rename(complete.waddr, complete.preg, complete.ppreg);
      end
    end
  end

  //--------------------------------------------------------------------------
  // Instruction encoding and reference model
  //--------------------------------------------------------------------------

  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm12);
    return {imm12, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm20);
    return {imm20, rd, 7'b0110111};
  endfunction

  // RV32I semantics straight from the instruction bits
  function automatic logic [31:0] model_result(input logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    a    = arf[inst[19:15]];
    b    = arf[inst[24:20]];
    simm = {{20{inst[31]}}, inst[31:20]};
    res  = 32'b0;
    case (inst[6:0])
      7'b0110011: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          default:         res = 32'b0;
        endcase
      end
      7'b0010011: res = (inst[14:12] == 3'b111) ? (a & simm) : (a + simm);
      7'b0110111: res = {inst[31:12], 12'b0};
      default:    res = 32'b0;
    endcase
    return res;
  endfunction

  // Random op that writes x16..x31 and reads only x1..x8
  function automatic logic [31:0] random_inst(input logic [31:0] r);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    rd  = {1'b1, r[3:0]};
    rs1 = {2'b00, r[6:4]} + 5'd1;
    rs2 = {2'b00, r[9:7]} + 5'd1;
    case (r[12:10])
      3'd0:    return r_type(7'b0000000, 3'b000, rd, rs1, rs2);
      3'd1:    return r_type(7'b0100000, 3'b000, rd, rs1, rs2);
      3'd2:    return r_type(7'b0000000, 3'b111, rd, rs1, rs2);
      3'd3:    return r_type(7'b0000000, 3'b110, rd, rs1, rs2);
      3'd4:    return r_type(7'b0000000, 3'b100, rd, rs1, rs2);
      3'd5:    return i_type(3'b000, rd, rs1, r[24:13]);
      3'd6:    return i_type(3'b111, rd, rs1, r[24:13]);
      default: return lui_inst(rd, r[31:12]);
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // Fetch driver
  //--------------------------------------------------------------------------

  // Predicts, then holds the item until the handshake at a rising edge
  task automatic send_inst(input logic [31:0] inst);
    expect_t e;
    e.waddr = inst[11:7];
    e.wen   = (inst[11:7] != 5'd0);
    e.wdata = model_result(inst);
    e.seq   = next_seq;
    exp_q.push_back(e);
    if (e.wen)
      arf[inst[11:7]] = e.wdata;
    fetch_in.inst = inst;
    fetch_in.pc   = 32'h1000 + {22'b0, next_seq, 2'b00};
    fetch_in.seq  = next_seq;
    fetch_val     = 1'b1;
    // fetch_rdy depends only on state and is stable at the falling edge
    while (!fetch_rdy)
      @(negedge clk);
    @(negedge clk);
    fetch_val = 1'b0;
    next_seq  = next_seq + 1'b1;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Completions stopped with %0d instructions outstanding", exp_q.size());
      end_with_failure();
    end
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------

  // Idle after reset while the monitor flags any stray completion
  task automatic reset_idle();
    check_value("fetch_rdy", 32'(fetch_rdy), 32'd1);
    repeat (10) @(negedge clk);
  endtask

  task automatic alu_ops();
    send_inst(i_type(3'b000, 5'd1, 5'd0, 12'h123));
    send_inst(i_type(3'b000, 5'd2, 5'd0, 12'hffb));
    send_inst(lui_inst(5'd3, 20'habcde));
    send_inst(i_type(3'b111, 5'd4, 5'd2, 12'h0f0));
    send_inst(r_type(7'b0000000, 3'b000, 5'd5, 5'd1, 5'd2));
    send_inst(r_type(7'b0100000, 3'b000, 5'd6, 5'd1, 5'd3));
    send_inst(r_type(7'b0000000, 3'b111, 5'd7, 5'd2, 5'd3));
    send_inst(r_type(7'b0000000, 3'b110, 5'd8, 5'd1, 5'd3));
    send_inst(r_type(7'b0000000, 3'b100, 5'd9, 5'd2, 5'd3));
    drain();
  endtask

  // Each op reads x10 written just before it
  task automatic dependent_chain();
    send_inst(i_type(3'b000, 5'd10, 5'd0, 12'h001));
    for (int i = 0; i < CHAIN_INSTS - 1; i++) begin
      case (i % 4)
        0:       send_inst(i_type(3'b000, 5'd10, 5'd10, 12'(i + 3)));
        1:       send_inst(r_type(7'b0000000, 3'b000, 5'd10, 5'd10, 5'd1));
        2:       send_inst(r_type(7'b0000000, 3'b100, 5'd10, 5'd10, 5'd3));
        default: send_inst(r_type(7'b0100000, 3'b000, 5'd10, 5'd10, 5'd2));
      endcase
    end
    drain();
  endtask

  // Eight writes to x11 need pregs handed back by completions
  task automatic free_list_reuse();
    for (int k = 0; k < FREE_INSTS - 1; k++)
      send_inst(i_type(3'b000, 5'd11, 5'd0, 12'(k * 7 + 1)));
    send_inst(r_type(7'b0000000, 3'b000, 5'd12, 5'd11, 5'd1));
    drain();
  endtask

  task automatic random_stream();
    int r;
    int gap;
    for (int n = 0; n < RANDOM_INSTS; n++) begin
      r   = $random(seed);
      gap = $random(seed);
      repeat (gap[1:0]) @(negedge clk);
      send_inst(random_inst(r));
    end
    drain();
  endtask

  // Results to x0 are dropped and x0 reads zero afterwards
  task automatic x0_writes();
    send_inst(i_type(3'b000, 5'd0, 5'd1, 12'h055));
    send_inst(lui_inst(5'd0, 20'h12345));
    send_inst(r_type(7'b0000000, 3'b000, 5'd13, 5'd0, 5'd0));
    send_inst(i_type(3'b000, 5'd14, 5'd0, 12'h007));
    send_inst(r_type(7'b0000000, 3'b100, 5'd15, 5'd0, 5'd1));
    drain();
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    seed      = 58463;
    rst       = 1'b1;
    fetch_val = 1'b0;
    fetch_in  = '0;
    next_seq  = '0;
    for (int i = 0; i < `RN_NUM_AREGS; i++) begin
      arf[i]  = 32'b0;
      pmap[i] = preg_t'(i);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_idle();
    alu_ops();
    dependent_chain();
    free_list_reuse();
    random_stream();
    x0_writes();

    if (exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Run ended with %0d completions missing", exp_q.size());
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
rename_pkg.sv
inst_decoder.sv
rename_table.sv
phys_regfile.sv
decode_issue_unit.sv
int_pipe.sv
decode_issue_top.sv
tb_decode_issue.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_decode_issue -f flist.f -o sim_tb &&
./obj_dir/sim_tb ||
exit 1
